// ==== Bender.yml ====
package:
  name: vec_unit

sources:
  - vec_pkg.sv
  - vec_dispatcher.sv
  - vec_sequencer.sv
  - vec_lane.sv
  - vec_lsu.sv
  - vec_top.sv
  - target: test
    files:
      - tb_vec_checker.sv
      - tb_vec_top.sv

// ==== files.f ====
vec_pkg.sv
vec_dispatcher.sv
vec_sequencer.sv
vec_lane.sv
vec_lsu.sv
vec_top.sv
tb_vec_checker.sv
tb_vec_top.sv

// ==== tb_vec_checker.sv ====
// Vector unit result checker
`default_nettype none
`timescale 1ns/1ns

module tb_vec_checker (
  input  logic               clk_i,
  input  logic               rst_i,
  input  logic [79:0]        test_name_i,
  // Core channels as seen at the DUT
  input  vec_pkg::acc_req_t  acc_req_i,
  input  logic               acc_req_valid_i,
  input  logic               acc_req_ready_i,
  input  vec_pkg::acc_resp_t acc_resp_i,
  input  logic               acc_resp_valid_i,
  input  logic               acc_resp_ready_i,
  // Wishbone traffic
  input  vec_pkg::wb_m2s_t   wb_m2s_i,
  input  vec_pkg::wb_s2m_t   wb_s2m_i,
  output int                 errors_o
);
  import vec_pkg::*;

  logic [ELEM_W-1:0] reg_model [NR_VREGS][NR_LANES];
  logic [ELEM_W-1:0] mem_model [64];
  logic              rst_q;
  logic              busy_q;
  logic              mem_op_q;
  logic              store_q;
  logic              exp_err_q;
  logic [2:0]        vreg_q;
  logic [24:0]       base_q;
  int                elem_q;
  logic              hold_q;
  acc_resp_t         held_resp_q;

  task automatic value_error(input string what, input logic [31:0] exp,
                             input logic [31:0] act);
    errors_o++;
    $display("FAIL %s %0s: expected %h, actual %h", test_name_i, what, exp, act);
  endtask

  task automatic plain_error(input string msg);
    errors_o++;
    $display("ERROR in %s: %0s", test_name_i, msg);
  endtask

  // Element-wise operation, subtract is vs1 minus vs2
  function automatic logic [31:0] alu_model(input logic [3:0] funct, input logic [31:0] a,
                                            input logic [31:0] b);
    case (funct)
      VADD:    return a + b;
      VSUB:    return a - b;
      VAND:    return a & b;
      default: return a ^ b;
    endcase
  endfunction

  initial begin
    errors_o = 0;
    for (int a = 0; a < 64; a++) begin
      mem_model[a] = 32'hC3A5_0000 ^ (a * 32'h0102_0305);
    end
  end

  always @(posedge clk_i) begin
    logic [31:0] insn;
    logic [3:0]  funct;
    logic [31:0] exp_dat;
    if (rst_i) begin
      busy_q = 1'b0;
      hold_q = 1'b0;
      for (int v = 0; v < NR_VREGS; v++) begin
        for (int k = 0; k < NR_LANES; k++) begin
          reg_model[v][k] = '0;
        end
      end
    end else begin
      if (rst_q && (acc_resp_valid_i || wb_m2s_i.cyc || wb_m2s_i.stb || !acc_req_ready_i)) begin
        plain_error("outputs are not in their reset state after reset");
      end

      ////////////////////
      // Response channel
      ////////////////////
      if (hold_q) begin
        if (!acc_resp_valid_i) begin
          plain_error("response was withdrawn before it was taken");
        end else if (acc_resp_i !== held_resp_q) begin
          value_error("held response", held_resp_q, acc_resp_i);
        end
      end
      if (acc_resp_valid_i && acc_req_ready_i) begin
        plain_error("request channel is ready while a response is pending");
      end
      if (busy_q && !acc_resp_valid_i && acc_req_ready_i) begin
        plain_error("request channel is ready while an instruction is outstanding");
      end
      if (acc_resp_valid_i && acc_resp_ready_i) begin
        if (!busy_q) begin
          plain_error("response arrived without an accepted request");
        end else begin
          if (acc_resp_i.error !== exp_err_q) begin
            value_error("error bit", exp_err_q, acc_resp_i.error);
          end
          if (mem_op_q && elem_q != NR_LANES) begin
            value_error("element count", NR_LANES, elem_q);
          end
        end
        busy_q = 1'b0;
      end
      hold_q      = acc_resp_valid_i && !acc_resp_ready_i;
      held_resp_q = acc_resp_i;

      ////////////////////
      // Wishbone cycles
      ////////////////////
      if (wb_m2s_i.cyc && !(busy_q && mem_op_q)) begin
        plain_error("Wishbone cycle without a memory instruction");
      end else if (wb_m2s_i.cyc && wb_m2s_i.stb && wb_s2m_i.ack) begin
        if (elem_q >= NR_LANES) begin
          plain_error("more Wishbone cycles than elements");
        end else begin
          if (wb_m2s_i.we !== store_q) begin
            value_error("write enable", store_q, wb_m2s_i.we);
          end
          if (wb_m2s_i.sel !== 4'hF) begin
            value_error("byte select", 32'hF, wb_m2s_i.sel);
          end
          if (wb_m2s_i.adr !== 32'((base_q + elem_q) * 4)) begin
            value_error("address", 32'((base_q + elem_q) * 4), wb_m2s_i.adr);
          end
          if (store_q) begin
            exp_dat = reg_model[vreg_q][elem_q];
            if (wb_m2s_i.dat !== exp_dat) begin
              value_error("store data", exp_dat, wb_m2s_i.dat);
            end
            mem_model[6'(base_q + elem_q)] = exp_dat;
          end
        end
        elem_q++;
      end

      ////////////////////
      // Accepted requests
      ////////////////////
      if (acc_req_valid_i && acc_req_ready_i) begin
        insn      = acc_req_i;
        funct     = insn[31:28];
        vreg_q    = insn[27:25];
        base_q    = insn[24:0];
        busy_q    = 1'b1;
        elem_q    = 0;
        mem_op_q  = (funct == VLD) || (funct == VST);
        store_q   = (funct == VST);
        exp_err_q = !(mem_op_q || funct inside {VADD, VSUB, VAND, VXOR});
        if (funct == VLD) begin
          for (int k = 0; k < NR_LANES; k++) begin
            reg_model[vreg_q][k] = mem_model[6'(base_q + k)];
          end
        end else if (!exp_err_q && !mem_op_q) begin
          for (int k = 0; k < NR_LANES; k++) begin
            reg_model[insn[27:25]][k] = alu_model(funct, reg_model[insn[24:22]][k],
                                                  reg_model[insn[21:19]][k]);
          end
        end
      end
    end
    rst_q = rst_i;
  end

endmodule : tb_vec_checker

`default_nettype wire

// ==== tb_vec_top.sv ====
// Vector unit testbench
`default_nettype none
`timescale 1ns/1ns

module tb_vec_top;
  import vec_pkg::*;

  localparam int TIMEOUT   = 200;
  localparam int MEM_WORDS = 64;

  // One stimulus row
  typedef struct packed {
    logic [79:0] name;
    logic [31:0] insn;
    logic [1:0]  stall;
  } row_t;

  logic              clk;
  logic              rst;
  acc_req_t          req;
  logic              req_valid;
  logic              req_ready;
  acc_resp_t         resp;
  logic              resp_valid;
  logic              resp_ready;
  wb_m2s_t           wb_m2s;
  wb_s2m_t           wb_s2m;
  logic [79:0]       test_name;
  int                check_errors;
  int                timeouts;
  logic [15:0]       lfsr_q;
  row_t              rows [$];
  logic [ELEM_W-1:0] mem [MEM_WORDS];

  initial clk = 1'b0;
  always #2 clk = ~clk;

  vec_top u_dut (
    .clk_i            (clk       ),
    .rst_i            (rst       ),
    .acc_req_i        (req       ),
    .acc_req_valid_i  (req_valid ),
    .acc_req_ready_o  (req_ready ),
    .acc_resp_o       (resp      ),
    .acc_resp_valid_o (resp_valid),
    .acc_resp_ready_i (resp_ready),
    .wb_o             (wb_m2s    ),
    .wb_i             (wb_s2m    )
  );

  tb_vec_checker u_chk (
    .clk_i            (clk         ),
    .rst_i            (rst         ),
    .test_name_i      (test_name   ),
    .acc_req_i        (req         ),
    .acc_req_valid_i  (req_valid   ),
    .acc_req_ready_i  (req_ready   ),
    .acc_resp_i       (resp        ),
    .acc_resp_valid_i (resp_valid  ),
    .acc_resp_ready_i (resp_ready  ),
    .wb_m2s_i         (wb_m2s      ),
    .wb_s2m_i         (wb_s2m      ),
    .errors_o         (check_errors)
  );

  ////////////////////
  // Helpers
  ////////////////////

  // Galois LFSR, taps 16, 14, 13, 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {1'b0, s[15:1]} ^ (s[0] ? 16'hB400 : 16'h0000);
  endfunction

  task automatic take_bits(input int n, output int v);
    v = 0;
    for (int i = 0; i < n; i++) begin
      v      = (v << 1) | lfsr_q[0];
      lfsr_q = lfsr_next(lfsr_q);
    end
  endtask

  function automatic logic [31:0] arith_word(input logic [3:0] f, input logic [2:0] vd,
                                             input logic [2:0] vs1, input logic [2:0] vs2);
    return {f, vd, vs1, vs2, 19'd0};
  endfunction

  function automatic logic [31:0] mem_word(input logic [3:0] f, input logic [2:0] vreg,
                                           input logic [24:0] base);
    return {f, vreg, base};
  endfunction

  task automatic add_row(input logic [79:0] name, input logic [31:0] insn);
    int stall;
    take_bits(2, stall);
    rows.push_back({name, insn, 2'(stall)});
  endtask

  // Send one instruction, then take its response after the row's stall
  task automatic run_row(input row_t row);
    int cnt;
    test_name = row.name;
    cnt = 0;
    while (!req_ready && cnt < TIMEOUT) begin
      @(posedge clk);
      #1;
      cnt++;
    end
    if (!req_ready) begin
      $display("Timeout in %s waiting for the request channel to become ready", row.name);
      timeouts++;
      return;
    end
    req       = row.insn;
    req_valid = 1'b1;
    @(posedge clk);
    #1;
    req_valid = 1'b0;
    cnt = 0;
    while (!resp_valid && cnt < TIMEOUT) begin
      @(posedge clk);
      #1;
      cnt++;
    end
    if (!resp_valid) begin
      $display("Timeout in %s waiting for the response", row.name);
      timeouts++;
      return;
    end
    for (int i = 0; i < row.stall; i++) begin
      @(posedge clk);
      #1;
    end
    resp_ready = 1'b1;
    @(posedge clk);
    #1;
    resp_ready = 1'b0;
  endtask

  ////////////////////
  // Wishbone memory
  ////////////////////

  // Ack after 0 to 3 wait cycles, held for one cycle
  always begin : wb_memory
    int   delay;
    logic pending;
    @(posedge clk);
    #1;
    if (rst) begin
      wb_s2m  = '0;
      pending = 1'b0;
    end else if (wb_s2m.ack) begin
      wb_s2m.ack = 1'b0;
    end else if (wb_m2s.cyc && wb_m2s.stb) begin
      if (!pending) begin
        take_bits(2, delay);
        pending = 1'b1;
      end
      if (delay == 0) begin
        wb_s2m.ack = 1'b1;
        pending    = 1'b0;
        if (wb_m2s.we) begin
          mem[wb_m2s.adr[7:2]] = wb_m2s.dat;
        end else begin
          wb_s2m.dat = mem[wb_m2s.adr[7:2]];
        end
      end else begin
        delay--;
      end
    end
  end

  initial begin
    rst        = 1'b1;
    req        = '0;
    req_valid  = 1'b0;
    resp_ready = 1'b0;
    wb_s2m     = '0;
    test_name  = "reset";
    timeouts   = 0;
    lfsr_q     = 16'd90;
    for (int a = 0; a < MEM_WORDS; a++) begin
      mem[a] = 32'hC3A5_0000 ^ (a * 32'h0102_0305);
    end

    add_row("load_v1",   mem_word(VLD, 3'd1, 25'd0));
    add_row("load_v2",   mem_word(VLD, 3'd2, 25'd8));
    add_row("store_v1",  mem_word(VST, 3'd1, 25'd32));
    add_row("add_v3",    arith_word(VADD, 3'd3, 3'd1, 3'd2));
    add_row("sub_v4",    arith_word(VSUB, 3'd4, 3'd1, 3'd2));
    add_row("store_v3",  mem_word(VST, 3'd3, 25'd36));
    add_row("store_v4",  mem_word(VST, 3'd4, 25'd40));
    add_row("and_v5",    arith_word(VAND, 3'd5, 3'd1, 3'd2));
    add_row("xor_v6",    arith_word(VXOR, 3'd6, 3'd1, 3'd2));
    add_row("store_v5",  mem_word(VST, 3'd5, 25'd44));
    add_row("store_v6",  mem_word(VST, 3'd6, 25'd48));
    // Decoded as arithmetic these would overwrite v1 and v2
    add_row("illegal_f", arith_word(4'hF, 3'd1, 3'd2, 3'd3));
    add_row("illegal_0", mem_word(4'h0, 3'd2, 25'd16));
    add_row("store_v1b", mem_word(VST, 3'd1, 25'd52));
    add_row("store_v2",  mem_word(VST, 3'd2, 25'd56));
    add_row("load_v7",   mem_word(VLD, 3'd7, 25'd36));
    add_row("store_v7",  mem_word(VST, 3'd7, 25'd60));

    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;
    for (int r = 0; r < rows.size(); r++) begin
      if (timeouts == 0) begin
        run_row(rows[r]);
      end
    end
    repeat (4) @(posedge clk);
    #1;
    $display("Checker errors: %0d, timeouts: %0d", check_errors, timeouts);
    if (check_errors == 0 && timeouts == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule : tb_vec_top

`default_nettype wire

// ==== vec_dispatcher.sv ====
// Vector instruction dispatcher
`default_nettype none
`timescale 1ns/1ns

module vec_dispatcher (
  input  logic               clk_i,
  input  logic               rst_i,
  // Core request and response
  input  vec_pkg::acc_req_t  acc_req_i,
  input  logic               acc_req_valid_i,
  output logic               acc_req_ready_o,
  output vec_pkg::acc_resp_t acc_resp_o,
  output logic               acc_resp_valid_o,
  input  logic               acc_resp_ready_i,
  // Sequencer side
  output vec_pkg::pe_req_t   seq_req_o,
  output logic               seq_req_valid_o,
  input  logic               seq_ready_i,
  input  logic               seq_done_i
);
  import vec_pkg::*;

  typedef enum logic [1:0] {IDLE, BUSY, RESP} state_e;

  state_e    state_q;
  logic      sent_q;
  logic      accept;
  vec_insn_u insn_q;
  acc_resp_t resp_q;

  assign acc_req_ready_o  = (state_q == IDLE);
  assign accept           = acc_req_valid_i && acc_req_ready_o;
  assign acc_resp_valid_o = (state_q == RESP);
  assign acc_resp_o       = resp_q;
  assign seq_req_valid_o  = (state_q == BUSY) && !sent_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= IDLE;
      sent_q  <= 1'b0;
    end else begin
      case (state_q)
        IDLE: begin
          if (accept) begin
            sent_q  <= 1'b0;
            // Illegal codes skip the sequencer and answer at once
            state_q <= is_legal(acc_req_i.insn.arith.funct) ? BUSY : RESP;
          end
        end
        BUSY: begin
          if (seq_req_valid_o && seq_ready_i) begin
            sent_q <= 1'b1;
          end
          if (seq_done_i) begin
            state_q <= RESP;
          end
        end
        RESP: begin
          if (acc_resp_ready_i) begin
            state_q <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // Instruction and response captured on acceptance
  always_ff @(posedge clk_i) begin
    if (accept) begin
      insn_q       <= acc_req_i.insn;
      resp_q.error <= !is_legal(acc_req_i.insn.arith.funct);
    end
  end

  ////////////////////
  // Decode
  ////////////////////

  always_comb begin
    seq_req_o       = '0;
    seq_req_o.funct = insn_q.arith.funct;
    if (is_mem(insn_q.mem.funct)) begin
      seq_req_o.vd   = insn_q.mem.vreg;
      seq_req_o.base = insn_q.mem.base;
    end else begin
      seq_req_o.vd  = insn_q.arith.vd;
      seq_req_o.vs1 = insn_q.arith.vs1;
      seq_req_o.vs2 = insn_q.arith.vs2;
    end
  end

  // Response held under back-pressure
  assert property (@(posedge clk_i) disable iff (rst_i)
    acc_resp_valid_o && !acc_resp_ready_i |=> acc_resp_valid_o && $stable(acc_resp_o));

endmodule : vec_dispatcher

`default_nettype wire

// ==== vec_lane.sv ====
// Vector lane
`default_nettype none
`timescale 1ns/1ns

module vec_lane (
  input  logic                       clk_i,
  input  logic                       rst_i,
  // Sequencer broadcast
  input  vec_pkg::pe_req_t           pe_req_i,
  input  logic                       pe_req_valid_i,
  // Load/store unit
  input  vec_pkg::lsu_wr_t           lsu_wr_i,
  output logic [vec_pkg::ELEM_W-1:0] stu_operand_o
);
  import vec_pkg::*;

  // This lane's slice of the register file
  logic [NR_VREGS-1:0][ELEM_W-1:0] vreg_q;
  logic [VREG_IDX_W-1:0]           st_vreg_q;
  logic [ELEM_W-1:0]               op_a;
  logic [ELEM_W-1:0]               op_b;
  logic [ELEM_W-1:0]               alu_res;

  ////////////////////
  // ALU
  ////////////////////

  assign op_a = vreg_q[pe_req_i.vs1];
  assign op_b = vreg_q[pe_req_i.vs2];

  always_comb begin
    case (pe_req_i.funct)
      VADD:    alu_res = op_a + op_b;
      VSUB:    alu_res = op_a - op_b;
      VAND:    alu_res = op_a & op_b;
      VXOR:    alu_res = op_a ^ op_b;
      default: alu_res = '0;
    endcase
  end

  ////////////////////
  // Register slice
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      vreg_q <= '0;
    end else if (pe_req_valid_i && is_arith(pe_req_i.funct)) begin
      vreg_q[pe_req_i.vd] <= alu_res;
    end else if (lsu_wr_i.valid) begin
      vreg_q[lsu_wr_i.vreg] <= lsu_wr_i.data;
    end
  end

  // Source register of the current store
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      st_vreg_q <= '0;
    end else if (pe_req_valid_i && (pe_req_i.funct == VST)) begin
      st_vreg_q <= pe_req_i.vd;
    end
  end

  assign stu_operand_o = vreg_q[st_vreg_q];

endmodule : vec_lane

`default_nettype wire

// ==== vec_lsu.sv ====
// Vector load/store unit
`default_nettype none
`timescale 1ns/1ns

module vec_lsu (
  input  logic                                             clk_i,
  input  logic                                             rst_i,
  // Sequencer broadcast
  input  vec_pkg::pe_req_t                                 pe_req_i,
  input  logic                                             pe_req_valid_i,
  output logic                                             lsu_done_o,
  // Lanes
  input  logic [vec_pkg::NR_LANES-1:0][vec_pkg::ELEM_W-1:0] stu_operand_i,
  output vec_pkg::lsu_wr_t [vec_pkg::NR_LANES-1:0]          lsu_wr_o,
  // Wishbone master
  output vec_pkg::wb_m2s_t                                 wb_o,
  input  vec_pkg::wb_s2m_t                                 wb_i
);
  import vec_pkg::*;

  logic                  busy_q;
  logic                  we_q;
  logic [VREG_IDX_W-1:0] vreg_q;
  logic [24:0]           base_q;
  logic [LANE_IDX_W-1:0] cnt_q;
  logic                  last_elem;
  logic [ELEM_W-1:0]     word_addr;

  assign last_elem  = (cnt_q == LANE_IDX_W'(NR_LANES - 1));
  assign lsu_done_o = busy_q && wb_i.ack && last_elem;

  // Element k lives at word base + k
  assign word_addr = ELEM_W'(base_q) + ELEM_W'(cnt_q);

  ////////////////////
  // Element counter
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      busy_q <= 1'b0;
      cnt_q  <= '0;
    end else if (!busy_q) begin
      if (pe_req_valid_i && is_mem(pe_req_i.funct)) begin
        busy_q <= 1'b1;
        cnt_q  <= '0;
      end
    end else if (wb_i.ack) begin
      cnt_q <= cnt_q + 1'b1;
      if (last_elem) begin
        busy_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!busy_q && pe_req_valid_i) begin
      we_q   <= (pe_req_i.funct == VST);
      vreg_q <= pe_req_i.vd;
      base_q <= pe_req_i.base;
    end
  end

  ////////////////////
  // Bus and lane ports
  ////////////////////

  always_comb begin
    wb_o.cyc = busy_q;
    wb_o.stb = busy_q;
    wb_o.we  = we_q;
    wb_o.adr = {word_addr[ELEM_W-3:0], 2'b00};
    wb_o.dat = stu_operand_i[cnt_q];
    wb_o.sel = '1;
  end

  // Load data goes only to the lane being counted
  always_comb begin
    for (int k = 0; k < NR_LANES; k++) begin
      lsu_wr_o[k].valid = busy_q && wb_i.ack && !we_q && (cnt_q == LANE_IDX_W'(k));
      lsu_wr_o[k].vreg  = vreg_q;
      lsu_wr_o[k].data  = wb_i.dat;
    end
  end

  // Strobe and address held while the slave stalls
  assert property (@(posedge clk_i) disable iff (rst_i)
    wb_o.stb && !wb_i.ack |=> wb_o.stb && $stable(wb_o.adr));

endmodule : vec_lsu

`default_nettype wire

// ==== vec_pkg.sv ====
// Vector unit shared definitions
`default_nettype none

package vec_pkg;

  ////////////////////
  // Geometry
  ////////////////////

  // One element per lane, so the lane count is also the vector length
  localparam int unsigned NR_LANES   = 4;
  localparam int unsigned NR_VREGS   = 8;
  localparam int unsigned ELEM_W     = 32;
  localparam int unsigned LANE_IDX_W = 2;
  localparam int unsigned VREG_IDX_W = 3;

  ////////////////////
  // Instructions
  ////////////////////

  typedef enum logic [3:0] {
    VADD = 4'd1,
    VSUB = 4'd2,
    VAND = 4'd3,
    VXOR = 4'd4,
    VLD  = 4'd8,
    VST  = 4'd9
  } vec_funct_e;

  // vd = vs1 op vs2
  typedef struct packed {
    vec_funct_e              funct;
    logic [VREG_IDX_W-1:0]   vd;
    logic [VREG_IDX_W-1:0]   vs1;
    logic [VREG_IDX_W-1:0]   vs2;
    logic [18:0]             unused;
  } vec_arith_t;

  // Base is a word address
  typedef struct packed {
    vec_funct_e              funct;
    logic [VREG_IDX_W-1:0]   vreg;
    logic [24:0]             base;
  } vec_mem_t;

  typedef union packed {
    vec_arith_t arith;
    vec_mem_t   mem;
  } vec_insn_u;

  typedef struct packed {
    vec_insn_u insn;
  } acc_req_t;

  typedef struct packed {
    logic error;
  } acc_resp_t;

  // Operation broadcast from the sequencer
  typedef struct packed {
    vec_funct_e              funct;
    logic [VREG_IDX_W-1:0]   vd;
    logic [VREG_IDX_W-1:0]   vs1;
    logic [VREG_IDX_W-1:0]   vs2;
    logic [24:0]             base;
  } pe_req_t;

  typedef struct packed {
    logic                    valid;
    logic [VREG_IDX_W-1:0]   vreg;
    logic [ELEM_W-1:0]       data;
  } lsu_wr_t;

  ////////////////////
  // Wishbone
  ////////////////////

  typedef struct packed {
    logic                    cyc;
    logic                    stb;
    logic                    we;
    logic [31:0]             adr;
    logic [ELEM_W-1:0]       dat;
    logic [3:0]              sel;
  } wb_m2s_t;

  typedef struct packed {
    logic                    ack;
    logic [ELEM_W-1:0]       dat;
  } wb_s2m_t;

  function automatic logic is_arith(vec_funct_e funct);
    return funct inside {VADD, VSUB, VAND, VXOR};
  endfunction

  function automatic logic is_mem(vec_funct_e funct);
    return funct inside {VLD, VST};
  endfunction

  function automatic logic is_legal(vec_funct_e funct);
    return is_arith(funct) || is_mem(funct);
  endfunction

endpackage : vec_pkg

`default_nettype wire

// ==== vec_sequencer.sv ====
// Vector operation sequencer
`default_nettype none
`timescale 1ns/1ns

module vec_sequencer (
  input  logic             clk_i,
  input  logic             rst_i,
  // Dispatcher side
  input  vec_pkg::pe_req_t seq_req_i,
  input  logic             seq_req_valid_i,
  output logic             seq_ready_o,
  output logic             seq_done_o,
  // Units
  output vec_pkg::pe_req_t pe_req_o,
  output logic             pe_req_valid_o,
  input  logic             lsu_done_i
);
  import vec_pkg::*;

  typedef enum logic [1:0] {IDLE, ISSUE, WAIT_LSU, DONE} state_e;

  state_e  state_q;
  pe_req_t req_q;

  assign seq_ready_o    = (state_q == IDLE);
  assign pe_req_valid_o = (state_q == ISSUE);
  assign seq_done_o     = (state_q == DONE);
  assign pe_req_o       = req_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= IDLE;
    end else begin
      case (state_q)
        IDLE: begin
          if (seq_req_valid_i) begin
            state_q <= ISSUE;
          end
        end
        ISSUE: begin
          // Lanes finish on this edge, memory ops take longer
          if (is_mem(req_q.funct)) begin
            state_q <= WAIT_LSU;
          end else begin
            state_q <= DONE;
          end
        end
        WAIT_LSU: begin
          if (lsu_done_i) begin
            state_q <= DONE;
          end
        end
        DONE: state_q <= IDLE;
        default: state_q <= IDLE;
      endcase
    end
  end

  // Operation in flight
  always_ff @(posedge clk_i) begin
    if (seq_req_valid_i && seq_ready_o) begin
      req_q <= seq_req_i;
    end
  end

  ////////////////////
  // Checks
  ////////////////////

  // One issue per operation
  assert property (@(posedge clk_i) disable iff (rst_i)
    pe_req_valid_o |=> !pe_req_valid_o);

  // Load/store unit only reports while waiting on it
  assert property (@(posedge clk_i) disable iff (rst_i)
    lsu_done_i |-> (state_q == WAIT_LSU));

endmodule : vec_sequencer

`default_nettype wire

// ==== vec_top.sv ====
// Vector coprocessor top level
`default_nettype none
`timescale 1ns/1ns

module vec_top (
  input  logic               clk_i,
  input  logic               rst_i,
  // Core interface
  input  vec_pkg::acc_req_t  acc_req_i,
  input  logic               acc_req_valid_i,
  output logic               acc_req_ready_o,
  output vec_pkg::acc_resp_t acc_resp_o,
  output logic               acc_resp_valid_o,
  input  logic               acc_resp_ready_i,
  // Memory
  output vec_pkg::wb_m2s_t   wb_o,
  input  vec_pkg::wb_s2m_t   wb_i
);
  import vec_pkg::*;

  pe_req_t                         seq_req;
  logic                            seq_req_valid;
  logic                            seq_ready;
  logic                            seq_done;
  pe_req_t                         pe_req;
  logic                            pe_req_valid;
  logic                            lsu_done;
  logic [NR_LANES-1:0][ELEM_W-1:0] stu_operand;
  lsu_wr_t [NR_LANES-1:0]          lsu_wr;

  vec_dispatcher u_dispatcher (
    .clk_i            (clk_i           ),
    .rst_i            (rst_i           ),
    .acc_req_i        (acc_req_i       ),
    .acc_req_valid_i  (acc_req_valid_i ),
    .acc_req_ready_o  (acc_req_ready_o ),
    .acc_resp_o       (acc_resp_o      ),
    .acc_resp_valid_o (acc_resp_valid_o),
    .acc_resp_ready_i (acc_resp_ready_i),
    .seq_req_o        (seq_req         ),
    .seq_req_valid_o  (seq_req_valid   ),
    .seq_ready_i      (seq_ready       ),
    .seq_done_i       (seq_done        )
  );

  vec_sequencer u_sequencer (
    .clk_i           (clk_i        ),
    .rst_i           (rst_i        ),
    .seq_req_i       (seq_req      ),
    .seq_req_valid_i (seq_req_valid),
    .seq_ready_o     (seq_ready    ),
    .seq_done_o      (seq_done     ),
    .pe_req_o        (pe_req       ),
    .pe_req_valid_o  (pe_req_valid ),
    .lsu_done_i      (lsu_done     )
  );

  for (genvar k = 0; k < NR_LANES; k++) begin : gen_lanes
    vec_lane u_lane (
      .clk_i          (clk_i         ),
      .rst_i          (rst_i         ),
      .pe_req_i       (pe_req        ),
      .pe_req_valid_i (pe_req_valid  ),
      .lsu_wr_i       (lsu_wr[k]     ),
      .stu_operand_o  (stu_operand[k])
    );
  end : gen_lanes

  vec_lsu u_lsu (
    .clk_i          (clk_i       ),
    .rst_i          (rst_i       ),
    .pe_req_i       (pe_req      ),
    .pe_req_valid_i (pe_req_valid),
    .lsu_done_o     (lsu_done    ),
    .stu_operand_i  (stu_operand ),
    .lsu_wr_o       (lsu_wr      ),
    .wb_o           (wb_o        ),
    .wb_i           (wb_i        )
  );

endmodule : vec_top

`default_nettype wire
